// File: rename_core.f
+incdir+tests
design/rename_pkg.sv
design/dispatch_unit.sv
design/map_table.sv
design/free_list.sv
design/reorder_buffer.sv
design/rename_core.sv
tests/rename_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rename core testbench with Verilator
# exit status is nonzero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f rename_core.f --top-module rename_core_tb \
    && ./obj_dir/Vrename_core_tb > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "ALL TESTS PASSED" sim.log && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

// File: tests/rename_checks.svh
/*
 * typed compare tasks and error counters for the rename core testbench
 * included inside the testbench module, after the package import
 */
`ifndef RENAME_CHECKS_SVH
`define RENAME_CHECKS_SVH

int error_count   = 0;  // wrong values
int timeout_count = 0;  // waits that ran out

task automatic check_phys(input string name, input phys_idx_t got, input phys_idx_t exp);
    if (got !== exp) begin
        error_count++;
        $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_rob(input string name, input rob_idx_t got, input rob_idx_t exp);
    if (got !== exp) begin
        error_count++;
        $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_arch(input string name, input arch_idx_t got, input arch_idx_t exp);
    if (got !== exp) begin
        error_count++;
        $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        error_count++;
        $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

// a wait that never saw its event
task automatic report_timeout(input string what);
    timeout_count++;
    $display("timeout: %s did not happen within the wait limit at %0t", what, $time);
endtask

`endif

// File: tests/rename_core_tb.sv
/*
 * directed testbench for the one-wide rename core
 * each test resets the DUT, drives dispatch and completion, checks renames and retirement
 */
`timescale 1ns/1ns

module rename_core_tb;
    import rename_pkg::*;

    localparam int WAIT_LIMIT = 64;  // cycles per wait

    logic       clock;
    logic       reset;
    logic       inst_valid;
    inst_word_t inst;
    logic       inst_ready;
    phys_idx_t  dst_phys;
    phys_idx_t  src1_phys;
    logic       src1_ready;
    phys_idx_t  src2_phys;
    logic       src2_ready;
    rob_idx_t   rob_idx;
    logic       complete_valid;
    rob_idx_t   complete_rob_idx;
    logic       retire_valid;
    arch_idx_t  retire_arch;
    phys_idx_t  retire_new_phys;
    phys_idx_t  retire_old_phys;

    // reference model for the random test
    phys_idx_t            model_map [ARCH_REGS];
    logic [PHYS_REGS-1:0] pending;       // renamed, not yet completed
    phys_idx_t            free_q [$];
    arch_idx_t            rob_arch_q [$];
    phys_idx_t            rob_new_q [$];
    phys_idx_t            rob_old_q [$];
    rob_idx_t             rob_idx_q [$];
    rob_idx_t             model_tail;
    integer               seed;

    `include "rename_checks.svh"

    rename_core u_dut (.*);

    always #20 clock = ~clock;  // 40 ns period

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    function automatic inst_word_t make_r(input arch_idx_t rd, input arch_idx_t rs1,
                                          input arch_idx_t rs2);
        inst_word_t w;
        w = '0;
        w.r_view.opcode = OPC_OP;
        w.r_view.rd     = rd;
        w.r_view.rs1    = rs1;
        w.r_view.rs2    = rs2;
        return w;
    endfunction

    function automatic inst_word_t make_i(input arch_idx_t rd, input arch_idx_t rs1,
                                          input logic [11:0] imm);
        inst_word_t w;
        w = '0;
        w.i_view.opcode = OPC_OP_IMM;
        w.i_view.rd     = rd;
        w.i_view.rs1    = rs1;
        w.i_view.imm    = imm;  // low bits land in the rs2 slot
        return w;
    endfunction

    task automatic apply_reset();
        reset          = 1'b1;
        inst_valid     = 1'b0;
        complete_valid = 1'b0;
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
    endtask

    // offer one instruction, check the renames in the accept cycle
    task automatic send_and_check(input inst_word_t word, input phys_idx_t exp_dst,
                                  input phys_idx_t exp_src1, input logic exp_ready1,
                                  input phys_idx_t exp_src2, input logic exp_ready2,
                                  input rob_idx_t exp_rob);
        int waited;
        waited     = 0;
        inst_valid = 1'b1;
        inst       = word;
        @(negedge clock);  // outputs settled mid-cycle
        while (!inst_ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (!inst_ready) begin
            report_timeout("dispatch handshake");
        end else begin
            check_phys("dst_phys", dst_phys, exp_dst);
            check_phys("src1_phys", src1_phys, exp_src1);
            check_bit("src1_ready", src1_ready, exp_ready1);
            check_phys("src2_phys", src2_phys, exp_src2);
            check_bit("src2_ready", src2_ready, exp_ready2);
            check_rob("rob_idx", rob_idx, exp_rob);
        end
        @(posedge clock);  // accepted here
        #2;
        inst_valid = 1'b0;
    endtask

    task automatic complete_entry(input rob_idx_t idx);
        complete_valid   = 1'b1;
        complete_rob_idx = idx;
        @(posedge clock);
        #2;
        complete_valid = 1'b0;
    endtask

    task automatic expect_retire(input arch_idx_t exp_arch, input phys_idx_t exp_new,
                                 input phys_idx_t exp_old);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!retire_valid && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (!retire_valid) begin
            report_timeout("retirement");
        end else begin
            check_arch("retire_arch", retire_arch, exp_arch);
            check_phys("retire_new_phys", retire_new_phys, exp_new);
            check_phys("retire_old_phys", retire_old_phys, exp_old);
        end
        @(posedge clock);
        #2;
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!inst_ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (!inst_ready)
            report_timeout("inst_ready rising");
        @(posedge clock);
        #2;
    endtask

    ////////////////////////////////////////
    // model driven traffic
    ////////////////////////////////////////
    task automatic reset_model();
        for (int i = 0; i < ARCH_REGS; i++)
            model_map[i] = phys_idx_t'(i);      // identity after reset
        pending = '0;
        free_q.delete();
        for (int i = ARCH_REGS; i < PHYS_REGS; i++)
            free_q.push_back(phys_idx_t'(i));  // 32..63
        rob_arch_q.delete();
        rob_new_q.delete();
        rob_old_q.delete();
        rob_idx_q.delete();
        model_tail = '0;
    endtask

    task automatic dispatch_random();
        arch_idx_t rd;
        arch_idx_t rs1;
        arch_idx_t rs2;
        phys_idx_t p1;
        phys_idx_t p2;
        rd  = arch_idx_t'(1 + {$random(seed)} % 31);  // never x0
        rs1 = arch_idx_t'({$random(seed)} % 32);
        rs2 = arch_idx_t'({$random(seed)} % 32);
        p1  = model_map[rs1];
        p2  = model_map[rs2];
        send_and_check(make_r(rd, rs1, rs2), free_q[0], p1, !pending[p1], p2, !pending[p2],
                       model_tail);
        rob_arch_q.push_back(rd);
        rob_new_q.push_back(free_q[0]);
        rob_old_q.push_back(model_map[rd]);  // mapping before this write
        rob_idx_q.push_back(model_tail);
        model_map[rd]      = free_q[0];
        pending[free_q[0]] = 1'b1;
        void'(free_q.pop_front());
        model_tail = model_tail + 1'b1;
    endtask

    // complete the oldest entry and see it leave
    task automatic retire_oldest();
        complete_entry(rob_idx_q[0]);
        pending[rob_new_q[0]] = 1'b0;
        expect_retire(rob_arch_q[0], rob_new_q[0], rob_old_q[0]);
        free_q.push_back(rob_old_q[0]);  // freed regs queue up behind the rest
        void'(rob_arch_q.pop_front());
        void'(rob_new_q.pop_front());
        void'(rob_old_q.pop_front());
        void'(rob_idx_q.pop_front());
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic first_allocations();
        apply_reset();
        send_and_check(make_r(5'd1, 5'd2, 5'd3), 6'd32, 6'd2, 1'b1, 6'd3, 1'b1, 4'd0);
        send_and_check(make_r(5'd4, 5'd5, 5'd6), 6'd33, 6'd5, 1'b1, 6'd6, 1'b1, 4'd1);
        send_and_check(make_r(5'd7, 5'd9, 5'd10), 6'd34, 6'd9, 1'b1, 6'd10, 1'b1, 4'd2);
    endtask

    task automatic dependency_wakeup();
        apply_reset();
        send_and_check(make_r(5'd5, 5'd1, 5'd2), 6'd32, 6'd1, 1'b1, 6'd2, 1'b1, 4'd0);
        send_and_check(make_r(5'd6, 5'd5, 5'd5), 6'd33, 6'd32, 1'b0, 6'd32, 1'b0, 4'd1);
        complete_entry(4'd0);
        send_and_check(make_r(5'd7, 5'd5, 5'd0), 6'd34, 6'd32, 1'b1, 6'd0, 1'b1, 4'd2);
        // completion of x6's producer in the lookup cycle, seen by both sources
        complete_valid   = 1'b1;
        complete_rob_idx = 4'd1;
        send_and_check(make_r(5'd8, 5'd6, 5'd6), 6'd35, 6'd33, 1'b1, 6'd33, 1'b1, 4'd3);
        complete_valid = 1'b0;
    endtask

    task automatic itype_and_x0();
        apply_reset();
        send_and_check(make_i(5'd9, 5'd3, 12'h0a5), 6'd32, 6'd3, 1'b1, 6'd0, 1'b1, 4'd0);
        // rs2 slot names x9, still no second source
        send_and_check(make_i(5'd10, 5'd9, 12'h009), 6'd33, 6'd32, 1'b0, 6'd0, 1'b1, 4'd1);
        send_and_check(make_r(5'd0, 5'd10, 5'd3), 6'd0, 6'd33, 1'b0, 6'd3, 1'b1, 4'd2);
        send_and_check(make_i(5'd0, 5'd1, 12'h7ff), 6'd0, 6'd1, 1'b1, 6'd0, 1'b1, 4'd3);
        send_and_check(make_r(5'd11, 5'd0, 5'd2), 6'd34, 6'd0, 1'b1, 6'd2, 1'b1, 4'd4);
    endtask

    task automatic inorder_retire();
        apply_reset();
        send_and_check(make_r(5'd1, 5'd2, 5'd3), 6'd32, 6'd2, 1'b1, 6'd3, 1'b1, 4'd0);
        send_and_check(make_r(5'd2, 5'd1, 5'd4), 6'd33, 6'd32, 1'b0, 6'd4, 1'b1, 4'd1);
        send_and_check(make_r(5'd1, 5'd2, 5'd5), 6'd34, 6'd33, 1'b0, 6'd5, 1'b1, 4'd2);
        complete_entry(4'd2);
        complete_entry(4'd1);
        @(negedge clock);
        check_bit("retire_valid", retire_valid, 1'b0);  // head still busy
        @(posedge clock);
        #2;
        complete_entry(4'd0);
        expect_retire(5'd1, 6'd32, 6'd1);
        expect_retire(5'd2, 6'd33, 6'd2);
        expect_retire(5'd1, 6'd34, 6'd32);
    endtask

    task automatic full_and_recycle();
        apply_reset();
        reset_model();
        repeat (ROB_DEPTH) dispatch_random();
        @(negedge clock);
        check_bit("inst_ready", inst_ready, 1'b0);  // rob full
        @(posedge clock);
        #2;
        retire_oldest();
        wait_ready();
        repeat (ROB_DEPTH - 1) retire_oldest();
        repeat (ROB_DEPTH) dispatch_random();      // uses up 48..63
        repeat (ROB_DEPTH) retire_oldest();
        repeat (ROB_DEPTH / 2) dispatch_random();  // recycled regs, FIFO order
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        inst_valid       = 1'b0;
        inst             = '0;
        complete_valid   = 1'b0;
        complete_rob_idx = '0;
        seed             = 32'he7bb720c;

        first_allocations();
        dependency_wakeup();
        itype_and_x0();
        inorder_retire();
        full_and_recycle();

        $display("checks done: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: design/rename_core.sv
/*
 * top of the one-wide rename core
 * dispatch port in, completion by rob index in, retirement reports out
 */
`timescale 1ns/1ns

module rename_core (
    input  logic                   clock,
    input  logic                   reset,

    // dispatch
    input  logic                   inst_valid,
    input  rename_pkg::inst_word_t inst,
    output logic                   inst_ready,
    output rename_pkg::phys_idx_t  dst_phys,
    output rename_pkg::phys_idx_t  src1_phys,
    output logic                   src1_ready,
    output rename_pkg::phys_idx_t  src2_phys,
    output logic                   src2_ready,
    output rename_pkg::rob_idx_t   rob_idx,

    // completion, no back-pressure
    input  logic                   complete_valid,
    input  rename_pkg::rob_idx_t   complete_rob_idx,

    // retirement
    output logic                   retire_valid,
    output rename_pkg::arch_idx_t  retire_arch,
    output rename_pkg::phys_idx_t  retire_new_phys,
    output rename_pkg::phys_idx_t  retire_old_phys
);
    import rename_pkg::*;

    // dispatch side
    logic       alloc_en;
    logic       alloc_dst;
    arch_idx_t  dst_arch;
    arch_idx_t  src1_arch;
    arch_idx_t  src2_arch;
    logic       src2_used;
    phys_idx_t  old_phys;

    // free list
    phys_idx_t  free_head;
    logic       free_empty;
    logic       free_pop;
    logic       free_push;

    // rob
    logic       rob_full;
    logic       done_valid;
    phys_idx_t  done_phys;
    logic       retire_has_dst;

    ////////////////////////////////////////
    // glue
    ////////////////////////////////////////
    assign free_pop  = alloc_en && alloc_dst;           // take a reg only for rd != x0
    assign free_push = retire_valid && retire_has_dst;  // hand back the old mapping
    assign dst_phys  = alloc_dst ? free_head : '0;      // x0 stays on phys 0

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////
    dispatch_unit u_dispatch (
        .inst_valid (inst_valid),
        .inst       (inst),
        .rob_full   (rob_full),     // <- rob
        .free_empty (free_empty),   // <- free list
        .inst_ready (inst_ready),
        .alloc_en   (alloc_en),
        .alloc_dst  (alloc_dst),
        .dst_arch   (dst_arch),     // -> map table, rob
        .src1_arch  (src1_arch),
        .src2_arch  (src2_arch),
        .src2_used  (src2_used)
    );

    map_table u_map (
        .clock (clock), .reset (reset),
        .alloc_en   (alloc_en),
        .alloc_dst  (alloc_dst),
        .dst_arch   (dst_arch),
        .src1_arch  (src1_arch),
        .src2_arch  (src2_arch),
        .src2_used  (src2_used),
        .new_phys   (dst_phys),
        .done_valid (done_valid),   // <- rob broadcast
        .done_phys  (done_phys),
        .src1_phys  (src1_phys),
        .src2_phys  (src2_phys),
        .old_phys   (old_phys),     // -> rob
        .src1_ready (src1_ready),
        .src2_ready (src2_ready)
    );

    free_list u_free (
        .clock (clock), .reset (reset),
        .pop       (free_pop),
        .push      (free_push),
        .push_phys (retire_old_phys),
        .head_phys (free_head),
        .empty     (free_empty)
    );

    reorder_buffer u_rob (
        .clock (clock), .reset (reset),
        .alloc_en         (alloc_en),
        .alloc_dst        (alloc_dst),
        .dst_arch         (dst_arch),
        .new_phys         (dst_phys),
        .old_phys         (old_phys),
        .complete_valid   (complete_valid),
        .complete_rob_idx (complete_rob_idx),
        .tail_idx         (rob_idx),
        .full             (rob_full),
        .done_valid       (done_valid),
        .done_phys        (done_phys),
        .retire_en        (retire_valid),
        .retire_has_dst   (retire_has_dst),
        .retire_arch      (retire_arch),
        .retire_new_phys  (retire_new_phys),
        .retire_old_phys  (retire_old_phys)
    );

endmodule

// File: design/reorder_buffer.sv
/*
 * in-order queue of dispatched instructions with done bits
 * completion by index sets done and broadcasts the tag, head retires when done
 */
`timescale 1ns/1ns

module reorder_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc_en,
    input  logic                  alloc_dst,
    input  rename_pkg::arch_idx_t dst_arch,
    input  rename_pkg::phys_idx_t new_phys,
    input  rename_pkg::phys_idx_t old_phys,
    input  logic                  complete_valid,
    input  rename_pkg::rob_idx_t  complete_rob_idx,

    output rename_pkg::rob_idx_t  tail_idx,        // slot the next dispatch gets
    output logic                  full,
    output logic                  done_valid,      // broadcast to the map table
    output rename_pkg::phys_idx_t done_phys,
    output logic                  retire_en,
    output logic                  retire_has_dst,
    output rename_pkg::arch_idx_t retire_arch,
    output rename_pkg::phys_idx_t retire_new_phys,
    output rename_pkg::phys_idx_t retire_old_phys
);
    import rename_pkg::*;

    // per-entry control
    logic [ROB_DEPTH-1:0] valid;
    logic [ROB_DEPTH-1:0] done;

    // per-entry payload, written at dispatch only
    logic                 has_dst  [ROB_DEPTH];
    arch_idx_t            arch     [ROB_DEPTH];
    phys_idx_t            phys_new [ROB_DEPTH];
    phys_idx_t            phys_old [ROB_DEPTH];

    rob_idx_t             head;
    rob_idx_t             tail;
    logic [ROB_W:0]       count;
    logic                 complete_hit;  // completion names a live, unfinished entry

    ////////////////////////////////////////
    // completion
    ////////////////////////////////////////
    // stale or repeated completions fall out here
    assign complete_hit = complete_valid && valid[complete_rob_idx] && !done[complete_rob_idx];

    assign done_valid = complete_hit && has_dst[complete_rob_idx];  // x0 writers stay quiet
    assign done_phys  = phys_new[complete_rob_idx];

    ////////////////////////////////////////
    // head / retirement
    ////////////////////////////////////////
    assign retire_en       = valid[head] && done[head];  // one per cycle at most
    assign retire_has_dst  = has_dst[head];
    assign retire_arch     = arch[head];
    assign retire_new_phys = phys_new[head];
    assign retire_old_phys = phys_old[head];

    assign tail_idx = tail;
    assign full     = (count == (ROB_W+1)'(ROB_DEPTH));

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (complete_hit)
                done[complete_rob_idx] <= 1'b1;
            if (alloc_en) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= tail + 1'b1;  // depth is a power of two
            end
            if (retire_en) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end

            case ({alloc_en, retire_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload captured at dispatch
    always_ff @(posedge clock) begin
        if (alloc_en) begin
            has_dst[tail]  <= alloc_dst;
            arch[tail]     <= dst_arch;
            phys_new[tail] <= new_phys;  // 0 when rd is x0
            phys_old[tail] <= old_phys;  // freed when this entry retires
        end
    end

endmodule

// File: design/free_list.sv
/*
 * circular FIFO of free physical register numbers
 * pops on allocation, pushes the old mapping back at retirement
 */
`timescale 1ns/1ns

module free_list (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pop,        // allocation with a destination
    input  logic                  push,       // retirement with a destination
    input  rename_pkg::phys_idx_t push_phys,  // old mapping being freed

    output rename_pkg::phys_idx_t head_phys,  // next register handed out
    output logic                  empty
);
    import rename_pkg::*;

    phys_idx_t         slots [FREE_DEPTH];
    logic [FREE_W-1:0] head;   // oldest free entry
    logic [FREE_W-1:0] tail;   // next write slot
    logic [FREE_W:0]   count;  // one extra bit, 0 to FREE_DEPTH

    ////////////////////////////////////////
    // pointers and storage
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                slots[i] <= phys_idx_t'(ARCH_REGS + i);  // 32..63 in order
            end
            head  <= '0;
            tail  <= '0;                                  // full, so tail wraps to head
            count <= (FREE_W+1)'(FREE_DEPTH);
        end else begin
            if (push) begin
                slots[tail] <= push_phys;
                tail <= (tail == FREE_W'(FREE_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop)
                head <= (head == FREE_W'(FREE_DEPTH - 1)) ? '0 : head + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither, net zero
            endcase
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////
    assign head_phys = slots[head];
    assign empty     = (count == '0);

endmodule

// File: design/map_table.sv
/*
 * speculative arch-to-phys map plus one ready bit per phys register
 * lookups are combinational and see a same-cycle completion broadcast
 */
`timescale 1ns/1ns

module map_table (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc_en,
    input  logic                  alloc_dst,
    input  rename_pkg::arch_idx_t dst_arch,
    input  rename_pkg::arch_idx_t src1_arch,
    input  rename_pkg::arch_idx_t src2_arch,
    input  logic                  src2_used,
    input  rename_pkg::phys_idx_t new_phys,    // head of the free list
    input  logic                  done_valid,  // completion broadcast
    input  rename_pkg::phys_idx_t done_phys,

    output rename_pkg::phys_idx_t src1_phys,
    output rename_pkg::phys_idx_t src2_phys,
    output rename_pkg::phys_idx_t old_phys,    // previous mapping of dst_arch
    output logic                  src1_ready,
    output logic                  src2_ready
);
    import rename_pkg::*;

    phys_idx_t              map [ARCH_REGS];
    logic [PHYS_REGS-1:0]   ready;

    ////////////////////////////////////////
    // state update
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= phys_idx_t'(i);  // identity map
            end
            ready <= '1;                   // every value is committed
        end else begin
            if (done_valid)
                ready[done_phys] <= 1'b1;  // producer finished
            if (alloc_en && alloc_dst) begin
                map[dst_arch]    <= new_phys;
                ready[new_phys]  <= 1'b0;  // new value not produced yet
            end
        end
    end

    ////////////////////////////////////////
    // lookups
    ////////////////////////////////////////
    assign src1_phys = map[src1_arch];
    assign old_phys  = map[dst_arch];  // read before this cycle's write

    // bypass so a broadcast in the lookup cycle already counts
    assign src1_ready = ready[src1_phys] || (done_valid && (done_phys == src1_phys));

    always_comb begin
        if (src2_used) begin
            src2_phys  = map[src2_arch];
            src2_ready = ready[src2_phys] || (done_valid && (done_phys == src2_phys));
        end else begin
            src2_phys  = '0;    // no second operand
            src2_ready = 1'b1;
        end
    end

endmodule

// File: design/dispatch_unit.sv
/*
 * decodes the incoming instruction and decides whether it can be taken
 * drives the allocate strobe and the map table lookup indices
 */
`timescale 1ns/1ns

module dispatch_unit (
    input  logic                   inst_valid,
    input  rename_pkg::inst_word_t inst,
    input  logic                   rob_full,     // no rob slot left
    input  logic                   free_empty,   // no free phys reg left

    output logic                   inst_ready,
    output logic                   alloc_en,     // instruction taken this cycle
    output logic                   alloc_dst,    // writes a nonzero rd
    output rename_pkg::arch_idx_t  dst_arch,
    output rename_pkg::arch_idx_t  src1_arch,
    output rename_pkg::arch_idx_t  src2_arch,
    output logic                   src2_used
);
    import rename_pkg::*;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    always_comb begin
        case (inst.r_view.opcode)
            OPC_OP:     src2_used = 1'b1;  // rs2 is a real source
            OPC_OP_IMM: src2_used = 1'b0;  // immediate sits in the rs2 slot
            default:    src2_used = 1'b0;  // everything else handled as i-type
        endcase
    end

    // shared fields, either view gives the same bits
    assign dst_arch  = inst.i_view.rd;
    assign src1_arch = inst.i_view.rs1;
    assign src2_arch = inst.r_view.rs2;  // don't care when src2_used is low

    // x0 writes are dropped, no phys reg needed
    assign alloc_dst = (dst_arch != '0);

    ////////////////////////////////////////
    // acceptance
    ////////////////////////////////////////
    // ready never looks at inst_valid
    // a free reg is only needed when there is a destination
    assign inst_ready = !rob_full && !(free_empty && alloc_dst);

    assign alloc_en = inst_valid && inst_ready;  // handshake fires

endmodule

// File: design/rename_pkg.sv
/*
 * shared sizes, index types and opcodes for the one-wide rename core
 * imported by every design block; widths follow from the counts below
 */
package rename_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int ARCH_REGS  = 32;                     // rv32 integer file
    localparam int PHYS_REGS  = 64;
    localparam int ROB_DEPTH  = 16;
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;  // regs not mapped at reset

    localparam int ARCH_W     = $clog2(ARCH_REGS);
    localparam int PHYS_W     = $clog2(PHYS_REGS);
    localparam int ROB_W      = $clog2(ROB_DEPTH);
    localparam int FREE_W     = $clog2(FREE_DEPTH);     // free list pointer width

    ////////////////////////////////////////
    // index types
    ////////////////////////////////////////
    typedef logic [ARCH_W-1:0] arch_idx_t;
    typedef logic [PHYS_W-1:0] phys_idx_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;

    // instruction word, seen as r-type or i-type
    // rd, rs1 and opcode sit at the same bits in both views
    typedef struct packed {
        logic [6:0] funct7;
        arch_idx_t  rs2;
        arch_idx_t  rs1;
        logic [2:0] funct3;
        arch_idx_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;       // rs2 and funct7 slots hold the immediate
        arch_idx_t   rs1;
        logic [2:0]  funct3;
        arch_idx_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
    } inst_word_t;

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // add, sub, and, ...
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // addi, andi, ...

endpackage
